// ==== source/chunk_core_pkg.sv ====
package chunk_core_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // register and bus word width
  localparam int XLEN      = 32;
  // register index width
  localparam int REG_ADR_W = 5;
  // size of the register file
  localparam int NUM_REGS  = 32;

  // ------------------------------
  // enums
  // ------------------------------

  // decoded operations, anything else runs as OP_NOP
  typedef enum logic [3:0] {
    OP_LUI,
    OP_ADDI,
    OP_XORI,
    OP_ORI,
    OP_ANDI,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_BEQ,
    OP_BNE,
    OP_SW,
    OP_NOP
  } op_e;

  // controller phases, one instruction at a time
  typedef enum logic [2:0] {
    PH_FETCH,
    PH_DECODE,
    PH_EXEC,
    PH_EXEC2,
    PH_STORE
  } phase_e;

  // chunk alu functions
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

endpackage

// ==== source/chunk_pc.sv ====
`timescale 1ns/100ps

module chunk_pc import chunk_core_pkg::*; #(
  parameter int          CHUNK_W  = 2,
  parameter logic [31:0] BOOT_ADR = 32'h0000_0000
) (
  input  logic               clk_i,
  input  logic               rst_in,
  input  logic               shift_en_i,
  input  phase_e             phase_i,
  input  logic               take_branch_i,
  input  logic [CHUNK_W-1:0] tgt_i,
  output logic [CHUNK_W-1:0] pc_ser_o,
  output logic [31:0]        pc_o
);

  localparam int NCHUNK = XLEN / CHUNK_W;
  // chunk that holds pc bit 2, and the bit inside that chunk
  localparam int K0      = (CHUNK_W >= 4) ? 0 : 2 / CHUNK_W;
  localparam int INC_BIT = (CHUNK_W >= 4) ? 2 : 0;
  localparam logic [NCHUNK-1:0] MARK_INIT = NCHUNK'(1) << K0;

  logic [XLEN-1:0]    pc_r;
  logic [NCHUNK-1:0]  mark_r;
  logic               carry_r;
  logic [CHUNK_W-1:0] inc_chunk;
  logic [CHUNK_W:0]   sum;
  logic               hold;
  logic               redirect;
  logic [CHUNK_W-1:0] din;

  assign pc_ser_o = pc_r[CHUNK_W-1:0];
  assign pc_o     = pc_r;

  // constant 4 as a chunk stream, marker rotates with the pc
  always_comb begin
    inc_chunk          = '0;
    inc_chunk[INC_BIT] = mark_r[0];
  end

  assign sum = {1'b0, pc_ser_o} + {1'b0, inc_chunk} + {{CHUNK_W{1'b0}}, carry_r};

  // first branch pass keeps the old pc, second pass may load the target
  assign hold     = take_branch_i & (phase_i == PH_EXEC);
  assign redirect = take_branch_i & (phase_i == PH_EXEC2);
  assign din      = hold ? pc_ser_o : (redirect ? tgt_i : sum[CHUNK_W-1:0]);

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      pc_r    <= BOOT_ADR;
      mark_r  <= MARK_INIT;
      carry_r <= 1'b0;
    end else if (shift_en_i) begin
      pc_r    <= {din, pc_r[XLEN-1:CHUNK_W]};
      mark_r  <= {mark_r[0], mark_r[NCHUNK-1:1]};
      // carry only lives through an incrementing pass
      carry_r <= (hold | redirect) ? 1'b0 : sum[CHUNK_W];
    end else begin
      carry_r <= 1'b0;
    end
  end

endmodule

// ==== source/chunk_cntrl.sv ====
`timescale 1ns/100ps

module chunk_cntrl import chunk_core_pkg::*; #(
  parameter int CHUNK_W = 2
) (
  input  logic   clk_i,
  input  logic   rst_in,
  input  logic   imem_ack_i,
  input  logic   dmem_ack_i,
  input  op_e    op_i,
  output phase_e phase_o,
  output logic   lsb_o,
  output logic   msb_o,
  output logic   shift_en_o,
  output logic   ir_load_o,
  output logic   imem_stb_o,
  output logic   dmem_stb_o
);

  localparam int NCHUNK = XLEN / CHUNK_W;
  localparam int CNT_W  = $clog2(NCHUNK);

  phase_e           phase_r;
  logic [CNT_W-1:0] cnt_r;
  logic             imem_stb_r;
  logic             dmem_stb_r;

  assign phase_o    = phase_r;
  assign imem_stb_o = imem_stb_r;
  assign dmem_stb_o = dmem_stb_r;

  // both execute passes move every chunk register
  assign shift_en_o = (phase_r == PH_EXEC) || (phase_r == PH_EXEC2);
  assign lsb_o      = (cnt_r == '0);
  assign msb_o      = (cnt_r == CNT_W'(NCHUNK - 1));

  // instruction word is valid in the ack cycle
  assign ir_load_o  = imem_stb_r & imem_ack_i;

  // ------------------------------
  // phase sequencer
  // ------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      phase_r    <= PH_FETCH;
      cnt_r      <= '0;
      imem_stb_r <= 1'b0;
      dmem_stb_r <= 1'b0;
    end else begin
      // power of two chunk count, wraps back to zero after msb
      if (shift_en_o) begin
        cnt_r <= cnt_r + 1'b1;
      end
      case (phase_r)
        PH_FETCH: begin
          // first fetch after reset raises the strobe here
          if (!imem_stb_r) begin
            imem_stb_r <= 1'b1;
          end else if (imem_ack_i) begin
            imem_stb_r <= 1'b0;
            phase_r    <= PH_DECODE;
          end
        end
        PH_DECODE: begin
          phase_r <= PH_EXEC;
        end
        PH_EXEC: begin
          if (msb_o) begin
            case (op_i)
              OP_BEQ, OP_BNE: begin
                phase_r <= PH_EXEC2;
              end
              OP_SW: begin
                phase_r    <= PH_STORE;
                dmem_stb_r <= 1'b1;
              end
              default: begin
                phase_r    <= PH_FETCH;
                imem_stb_r <= 1'b1;
              end
            endcase
          end
        end
        PH_EXEC2: begin
          // second branch pass, pc now holds target or pc+4
          if (msb_o) begin
            phase_r    <= PH_FETCH;
            imem_stb_r <= 1'b1;
          end
        end
        PH_STORE: begin
          if (dmem_ack_i) begin
            dmem_stb_r <= 1'b0;
            phase_r    <= PH_FETCH;
            imem_stb_r <= 1'b1;
          end
        end
        default: begin
          phase_r <= PH_FETCH;
        end
      endcase
    end
  end

  // ------------------------------
  // bus checks
  // ------------------------------

  // fetch request is held until the memory answers
  a_imem_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_in)
    imem_stb_o && !imem_ack_i |=> imem_stb_o);

  // fetch and store never overlap on the two buses
  a_stb_excl: assert property (@(posedge clk_i) disable iff (!rst_in)
    !(imem_stb_o && dmem_stb_o));

endmodule

// ==== source/chunk_decode.sv ====
`timescale 1ns/100ps

module chunk_decode import chunk_core_pkg::*; #(
  parameter int CHUNK_W = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_in,
  input  logic                 ir_load_i,
  input  logic [31:0]          imem_dat_i,
  input  phase_e               phase_i,
  input  logic                 shift_en_i,
  input  logic                 eq_i,
  output op_e                  op_o,
  output alu_op_e              alu_op_o,
  output logic                 use_imm_o,
  output logic                 rf_we_o,
  output logic [REG_ADR_W-1:0] rs1_o,
  output logic [REG_ADR_W-1:0] rs2_o,
  output logic [REG_ADR_W-1:0] rd_o,
  output logic [CHUNK_W-1:0]   imm_ser_o,
  output logic                 take_branch_o
);

  logic [31:0]     ir_r;
  logic [XLEN-1:0] imm_r;
  logic [XLEN-1:0] imm_par;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            is_br;
  logic            br_cond_r;

  assign opcode = ir_r[6:0];
  assign funct3 = ir_r[14:12];
  assign funct7 = ir_r[31:25];

  assign rs1_o  = ir_r[19:15];
  assign rs2_o  = ir_r[24:20];
  assign rd_o   = ir_r[11:7];

  // cleared ir decodes as a no-op
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      ir_r <= '0;
    end else if (ir_load_i) begin
      ir_r <= imem_dat_i;
    end
  end

  // ------------------------------
  // opcode map
  // ------------------------------

  always_comb begin
    op_o = OP_NOP;
    case (opcode)
      7'b0110111: op_o = OP_LUI;
      7'b0010011: begin
        case (funct3)
          3'b000:  op_o = OP_ADDI;
          3'b100:  op_o = OP_XORI;
          3'b110:  op_o = OP_ORI;
          3'b111:  op_o = OP_ANDI;
          default: op_o = OP_NOP;
        endcase
      end
      7'b0110011: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op_o = OP_ADD;
            3'b100:  op_o = OP_XOR;
            3'b110:  op_o = OP_OR;
            3'b111:  op_o = OP_AND;
            default: op_o = OP_NOP;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op_o = OP_SUB;
        end
      end
      7'b1100011: begin
        if (funct3 == 3'b000) op_o = OP_BEQ;
        if (funct3 == 3'b001) op_o = OP_BNE;
      end
      7'b0100011: begin
        if (funct3 == 3'b010) op_o = OP_SW;
      end
      default: op_o = OP_NOP;
    endcase
  end

  assign is_br = (op_o == OP_BEQ) || (op_o == OP_BNE);

  always_comb begin
    alu_op_o  = ALU_ADD;
    use_imm_o = 1'b0;
    rf_we_o   = 1'b1;
    case (op_o)
      OP_LUI:  begin alu_op_o = ALU_PASS_B; use_imm_o = 1'b1; end
      OP_ADDI: use_imm_o = 1'b1;
      OP_XORI: begin alu_op_o = ALU_XOR; use_imm_o = 1'b1; end
      OP_ORI:  begin alu_op_o = ALU_OR;  use_imm_o = 1'b1; end
      OP_ANDI: begin alu_op_o = ALU_AND; use_imm_o = 1'b1; end
      OP_ADD:  alu_op_o = ALU_ADD;
      OP_SUB:  alu_op_o = ALU_SUB;
      OP_XOR:  alu_op_o = ALU_XOR;
      OP_OR:   alu_op_o = ALU_OR;
      OP_AND:  alu_op_o = ALU_AND;
      // compare pass on registers, then pc plus offset
      OP_BEQ, OP_BNE: begin
        use_imm_o = (phase_i == PH_EXEC2);
        rf_we_o   = 1'b0;
      end
      OP_SW:   begin use_imm_o = 1'b1; rf_we_o = 1'b0; end
      default: rf_we_o = 1'b0;
    endcase
  end

  // ------------------------------
  // immediate
  // ------------------------------

  always_comb begin
    case (op_o)
      OP_LUI:         imm_par = {ir_r[31:12], 12'b0};
      OP_SW:          imm_par = {{20{ir_r[31]}}, ir_r[31:25], ir_r[11:7]};
      OP_BEQ, OP_BNE: imm_par = {{19{ir_r[31]}}, ir_r[31], ir_r[7], ir_r[30:25],
                                 ir_r[11:8], 1'b0};
      default:        imm_par = {{20{ir_r[31]}}, ir_r[31:20]};
    endcase
  end

  // rotates so a branch still has it for the second pass
  always_ff @(posedge clk_i) begin
    if (phase_i == PH_DECODE) begin
      imm_r <= imm_par;
    end else if (shift_en_i) begin
      imm_r <= {imm_r[CHUNK_W-1:0], imm_r[XLEN-1:CHUNK_W]};
    end
  end

  assign imm_ser_o = imm_r[CHUNK_W-1:0];

  // running compare settles at the msb of the first pass
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      br_cond_r <= 1'b0;
    end else if (shift_en_i && phase_i == PH_EXEC) begin
      br_cond_r <= (op_o == OP_BNE) ? ~eq_i : eq_i;
    end
  end

  // pass one: pc holds, pass two: pc loads target if condition met
  assign take_branch_o = is_br & ((phase_i == PH_EXEC) | br_cond_r);

endmodule

// ==== source/chunk_regfile.sv ====
`timescale 1ns/100ps

module chunk_regfile import chunk_core_pkg::*; #(
  parameter int CHUNK_W = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_in,
  input  phase_e               phase_i,
  input  logic                 shift_en_i,
  input  logic                 msb_i,
  input  logic [REG_ADR_W-1:0] rs1_i,
  input  logic [REG_ADR_W-1:0] rs2_i,
  input  logic [REG_ADR_W-1:0] rd_i,
  input  logic                 we_i,
  input  logic [CHUNK_W-1:0]   res_i,
  output logic [CHUNK_W-1:0]   ra_o,
  output logic [CHUNK_W-1:0]   rb_o
);

  logic [XLEN-1:0]         regs [NUM_REGS];
  logic [XLEN-1:0]         ra_r;
  logic [XLEN-1:0]         rb_r;
  // result chunks below the last one
  logic [XLEN-CHUNK_W-1:0] wb_r;
  logic                    wr_en;

  assign ra_o = ra_r[CHUNK_W-1:0];
  assign rb_o = rb_r[CHUNK_W-1:0];

  // operand words in at decode, then one chunk per cycle
  always_ff @(posedge clk_i) begin
    if (phase_i == PH_DECODE) begin
      // x0 is never written, so mask it here
      ra_r <= (rs1_i == '0) ? '0 : regs[rs1_i];
      rb_r <= (rs2_i == '0) ? '0 : regs[rs2_i];
    end else if (shift_en_i) begin
      ra_r <= {ra_r[CHUNK_W-1:0], ra_r[XLEN-1:CHUNK_W]};
      rb_r <= {rb_r[CHUNK_W-1:0], rb_r[XLEN-1:CHUNK_W]};
      wb_r <= {res_i, wb_r[XLEN-CHUNK_W-1:CHUNK_W]};
    end
  end

  // ------------------------------
  // write-back
  // ------------------------------

  // last chunk goes straight in with the collected ones
  assign wr_en = (phase_i == PH_EXEC) & shift_en_i & msb_i & we_i & (rd_i != '0);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      regs[rd_i] <= {res_i, wb_r};
    end
  end

  // an x0 operand streams zero chunks through every execute pass
  a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_in)
    shift_en_i |-> ((rs1_i != '0) || (ra_o == '0)) && ((rs2_i != '0) || (rb_o == '0)));

endmodule

// ==== source/chunk_alu.sv ====
`timescale 1ns/100ps

module chunk_alu import chunk_core_pkg::*; #(
  parameter int CHUNK_W = 2
) (
  input  logic               clk_i,
  input  logic               lsb_i,
  input  logic               shift_en_i,
  input  alu_op_e            alu_op_i,
  input  logic [CHUNK_W-1:0] a_i,
  input  logic [CHUNK_W-1:0] b_i,
  output logic [CHUNK_W-1:0] res_o,
  output logic               eq_o
);

  logic               sub;
  logic [CHUNK_W-1:0] b_eff;
  logic               cin;
  logic [CHUNK_W:0]   sum;
  logic               carry_r;
  logic               ne_r;

  // subtract as a plus inverted b plus one
  assign sub   = (alu_op_i == ALU_SUB);
  assign b_eff = sub ? ~b_i : b_i;
  // fresh carry on the first chunk
  assign cin   = lsb_i ? sub : carry_r;
  assign sum   = {1'b0, a_i} + {1'b0, b_eff} + {{CHUNK_W{1'b0}}, cin};

  always_comb begin
    case (alu_op_i)
      ALU_ADD, ALU_SUB: res_o = sum[CHUNK_W-1:0];
      ALU_XOR:          res_o = a_i ^ b_i;
      ALU_OR:           res_o = a_i | b_i;
      ALU_AND:          res_o = a_i & b_i;
      ALU_PASS_B:       res_o = b_i;
      default:          res_o = '0;
    endcase
  end

  // equal so far, including this chunk
  assign eq_o = (a_i == b_i) & (lsb_i | ~ne_r);

  always_ff @(posedge clk_i) begin
    if (shift_en_i) begin
      carry_r <= sum[CHUNK_W];
      ne_r    <= ~eq_o;
    end
  end

endmodule

// ==== source/chunk_lsu.sv ====
`timescale 1ns/100ps

module chunk_lsu import chunk_core_pkg::*; #(
  parameter int CHUNK_W = 2
) (
  input  logic               clk_i,
  input  logic               shift_en_i,
  input  phase_e             phase_i,
  input  logic [CHUNK_W-1:0] res_i,
  input  logic [CHUNK_W-1:0] rb_i,
  output logic [31:0]        dmem_adr_o,
  output logic               dmem_we_o,
  output logic [31:0]        dmem_dat_o
);

  logic [XLEN-1:0] adr_r;
  logic [XLEN-1:0] dat_r;

  // address from the alu sum, data straight from rs2
  always_ff @(posedge clk_i) begin
    if (shift_en_i && phase_i == PH_EXEC) begin
      adr_r <= {res_i, adr_r[XLEN-1:CHUNK_W]};
      dat_r <= {rb_i, dat_r[XLEN-1:CHUNK_W]};
    end
  end

  // word access only
  assign dmem_adr_o = {adr_r[XLEN-1:2], 2'b00};
  assign dmem_dat_o = dat_r;
  // stores are the only data access
  assign dmem_we_o  = (phase_i == PH_STORE);

endmodule

// ==== source/chunk_core.sv ====
`timescale 1ns/100ps

module chunk_core import chunk_core_pkg::*; #(
  parameter int          CHUNK_W  = 2,
  parameter logic [31:0] BOOT_ADR = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        rst_in,
  output logic        imem_stb_o,
  output logic [31:0] imem_adr_o,
  input  logic [31:0] imem_dat_i,
  input  logic        imem_ack_i,
  output logic        dmem_stb_o,
  output logic        dmem_we_o,
  output logic [31:0] dmem_adr_o,
  output logic [31:0] dmem_dat_o,
  input  logic        dmem_ack_i
);

  // control broadcast
  phase_e               phase;
  logic                 lsb;
  logic                 msb;
  logic                 shift_en;
  logic                 ir_load;

  // decoded fields
  op_e                  op;
  alu_op_e              alu_op;
  logic                 use_imm;
  logic                 rf_we;
  logic [REG_ADR_W-1:0] rs1;
  logic [REG_ADR_W-1:0] rs2;
  logic [REG_ADR_W-1:0] rd;
  logic [CHUNK_W-1:0]   imm_ser;
  logic                 take_branch;

  // chunk data path
  logic [CHUNK_W-1:0]   ra;
  logic [CHUNK_W-1:0]   rb;
  logic [CHUNK_W-1:0]   alu_a;
  logic [CHUNK_W-1:0]   alu_b;
  logic [CHUNK_W-1:0]   res;
  logic                 eq;
  logic [CHUNK_W-1:0]   pc_ser;

  // ------------------------------
  // operand select
  // ------------------------------

  // second branch pass adds the offset to the old pc
  assign alu_a = (phase == PH_EXEC2) ? pc_ser : ra;
  assign alu_b = use_imm ? imm_ser : rb;

  chunk_cntrl #(.CHUNK_W(CHUNK_W)) i_cntrl (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .imem_ack_i (imem_ack_i),
    .dmem_ack_i (dmem_ack_i),
    .op_i       (op),
    .phase_o    (phase),
    .lsb_o      (lsb),
    .msb_o      (msb),
    .shift_en_o (shift_en),
    .ir_load_o  (ir_load),
    .imem_stb_o (imem_stb_o),
    .dmem_stb_o (dmem_stb_o)
  );

  chunk_decode #(.CHUNK_W(CHUNK_W)) i_decode (
    .clk_i         (clk_i),
    .rst_in        (rst_in),
    .ir_load_i     (ir_load),
    .imem_dat_i    (imem_dat_i),
    .phase_i       (phase),
    .shift_en_i    (shift_en),
    .eq_i          (eq),
    .op_o          (op),
    .alu_op_o      (alu_op),
    .use_imm_o     (use_imm),
    .rf_we_o       (rf_we),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd),
    .imm_ser_o     (imm_ser),
    .take_branch_o (take_branch)
  );

  chunk_regfile #(.CHUNK_W(CHUNK_W)) i_regfile (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .phase_i    (phase),
    .shift_en_i (shift_en),
    .msb_i      (msb),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rd),
    .we_i       (rf_we),
    .res_i      (res),
    .ra_o       (ra),
    .rb_o       (rb)
  );

  chunk_alu #(.CHUNK_W(CHUNK_W)) i_alu (
    .clk_i      (clk_i),
    .lsb_i      (lsb),
    .shift_en_i (shift_en),
    .alu_op_i   (alu_op),
    .a_i        (alu_a),
    .b_i        (alu_b),
    .res_o      (res),
    .eq_o       (eq)
  );

  // pc word doubles as the fetch address
  chunk_pc #(.CHUNK_W(CHUNK_W), .BOOT_ADR(BOOT_ADR)) i_pc (
    .clk_i         (clk_i),
    .rst_in        (rst_in),
    .shift_en_i    (shift_en),
    .phase_i       (phase),
    .take_branch_i (take_branch),
    .tgt_i         (res),
    .pc_ser_o      (pc_ser),
    .pc_o          (imem_adr_o)
  );

  chunk_lsu #(.CHUNK_W(CHUNK_W)) i_lsu (
    .clk_i      (clk_i),
    .shift_en_i (shift_en),
    .phase_i    (phase),
    .res_i      (res),
    .rb_i       (rb),
    .dmem_adr_o (dmem_adr_o),
    .dmem_we_o  (dmem_we_o),
    .dmem_dat_o (dmem_dat_o)
  );

endmodule

// ==== tb/chunk_core_tb.sv ====
`timescale 1ns/100ps

module chunk_core_tb import chunk_core_pkg::*; ();

  localparam int          CHUNK_W    = 2;
  localparam logic [31:0] BOOT_ADR   = 32'h0000_0100;
  localparam int          PROG_LEN   = 31;
  // last word of the program branches to itself
  localparam logic [31:0] LOOP_ADR   = BOOT_ADR + 32'(4 * (PROG_LEN - 1));
  // two passes plus both bus waits per instruction, worst case
  localparam int          MAX_CYCLES = PROG_LEN * (2 * XLEN / CHUNK_W + 12);
  // addi x0, x0, 0
  localparam logic [31:0] NOP        = 32'h0000_0013;

  logic        clk_i;
  logic        rst_in;
  logic        imem_stb_o;
  logic [31:0] imem_adr_o;
  logic [31:0] imem_dat_i;
  logic        imem_ack_i;
  logic        dmem_stb_o;
  logic        dmem_we_o;
  logic [31:0] dmem_adr_o;
  logic [31:0] dmem_dat_o;
  logic        dmem_ack_i;

  logic [31:0] rom [PROG_LEN];
  logic [31:0] ref_regs [NUM_REGS];
  // model state, moves on each fetch ack
  logic [31:0] exp_pc;
  logic [31:0] exp_adr;
  logic [31:0] exp_dat;
  logic        st_pending;
  int          fetch_cnt;
  int          loop_hits;
  int          st_ref;
  int          st_seen;
  int          err_cnt;
  int          to_cnt;
  int          cycles;
  integer      seed;
  logic [1:0]  i_wait;
  logic [1:0]  d_wait;

  chunk_core #(.CHUNK_W(CHUNK_W), .BOOT_ADR(BOOT_ADR)) uut (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .imem_stb_o (imem_stb_o),
    .imem_adr_o (imem_adr_o),
    .imem_dat_i (imem_dat_i),
    .imem_ack_i (imem_ack_i),
    .dmem_stb_o (dmem_stb_o),
    .dmem_we_o  (dmem_we_o),
    .dmem_adr_o (dmem_adr_o),
    .dmem_dat_o (dmem_dat_o),
    .dmem_ack_i (dmem_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------
  // instruction encoders
  // ------------------------------

  function automatic logic [31:0] reg_alu(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_alu(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] upper(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, rs1,
                                             input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // offset in bytes, bit 0 dropped by the format
  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [12:0] ofs);
    return {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], 7'b1100011};
  endfunction

  task automatic load_program();
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    rom[0]  = upper(5'd1, 20'h12345);
    rom[1]  = imm_alu(3'b000, 5'd1, 5'd1, 12'h678);
    rom[2]  = imm_alu(3'b000, 5'd2, 5'd0, 12'hFFF);
    // carry ripples through every chunk
    rom[3]  = reg_alu(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    rom[4]  = imm_alu(3'b000, 5'd10, 5'd0, 12'h200);
    rom[5]  = store_word(5'd3, 5'd10, 12'h000);
    rom[6]  = reg_alu(7'h20, 3'b000, 5'd4, 5'd0, 5'd1);
    rom[7]  = store_word(5'd4, 5'd10, 12'hFFC);
    rom[8]  = reg_alu(7'h00, 3'b100, 5'd5, 5'd1, 5'd2);
    rom[9]  = reg_alu(7'h00, 3'b110, 5'd6, 5'd1, 5'd4);
    rom[10] = reg_alu(7'h00, 3'b111, 5'd7, 5'd3, 5'd5);
    rom[11] = store_word(5'd5, 5'd10, 12'h008);
    rom[12] = store_word(5'd6, 5'd10, 12'h00C);
    // unaligned offset, low address bits must come out cleared
    rom[13] = store_word(5'd7, 5'd10, 12'h011);
    rom[14] = imm_alu(3'b100, 5'd8, 5'd1, 12'hF00);
    rom[15] = imm_alu(3'b110, 5'd9, 5'd4, 12'h0F0);
    rom[16] = imm_alu(3'b111, 5'd11, 5'd3, 12'hFF0);
    rom[17] = store_word(5'd8, 5'd10, 12'h014);
    rom[18] = store_word(5'd9, 5'd10, 12'h018);
    rom[19] = store_word(5'd11, 5'd10, 12'h01C);
    rom[20] = imm_alu(3'b000, 5'd12, 5'd1, 12'h800);
    // beq not taken, then bne taken over a store
    rom[21] = branch(3'b000, 5'd1, 5'd12, 13'd8);
    rom[22] = branch(3'b001, 5'd1, 5'd12, 13'd8);
    rom[23] = store_word(5'd0, 5'd0, 12'h000);
    rom[24] = branch(3'b000, 5'd2, 5'd2, 13'd8);
    rom[25] = imm_alu(3'b000, 5'd12, 5'd0, 12'h001);
    rom[26] = store_word(5'd12, 5'd10, 12'h020);
    rom[27] = branch(3'b001, 5'd3, 5'd3, 13'd8);
    rom[28] = upper(5'd13, 20'hFEDCB);
    rom[29] = store_word(5'd13, 5'd10, 12'h800);
    rom[30] = branch(3'b000, 5'd0, 5'd0, 13'd0);
  endtask

  // outside the program the memory returns no-ops
  function automatic logic [31:0] rom_word(input logic [31:0] adr);
    logic [31:0] idx;
    idx = (adr - BOOT_ADR) >> 2;
    if (idx < 32'(PROG_LEN)) begin
      return rom[idx];
    end
    return NOP;
  endfunction

  // ------------------------------
  // bus responders
  // ------------------------------

  // random wait before each ack, both buses in one block
  always @(posedge clk_i) begin
    if (!rst_in) begin
      imem_ack_i <= 1'b0;
      dmem_ack_i <= 1'b0;
      i_wait     <= 2'($random(seed));
      d_wait     <= 2'($random(seed));
    end else begin
      if (imem_ack_i) begin
        imem_ack_i <= 1'b0;
      end else if (imem_stb_o) begin
        if (i_wait == 2'd0) begin
          imem_ack_i <= 1'b1;
          imem_dat_i <= rom_word(imem_adr_o);
          i_wait     <= 2'($random(seed));
        end else begin
          i_wait <= i_wait - 1'b1;
        end
      end
      if (dmem_ack_i) begin
        dmem_ack_i <= 1'b0;
      end else if (dmem_stb_o) begin
        if (d_wait == 2'd0) begin
          dmem_ack_i <= 1'b1;
          d_wait     <= 2'($random(seed));
        end else begin
          d_wait <= d_wait - 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------

  task automatic execute_ref(input logic [31:0] ins);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] res;
    logic        wr;
    rd    = ins[11:7];
    rs1   = ins[19:15];
    rs2   = ins[24:20];
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    a     = ref_regs[rs1];
    b     = ref_regs[rs2];
    wr    = 1'b0;
    res   = '0;
    // sequential unless a taken branch overrides below
    exp_pc <= exp_pc + 32'd4;
    case (ins[6:0])
      7'b0110111: begin
        res = {ins[31:12], 12'h000};
        wr  = 1'b1;
      end
      7'b0010011: begin
        wr = 1'b1;
        case (f3)
          3'b000:  res = a + imm_i;
          3'b100:  res = a ^ imm_i;
          3'b110:  res = a | imm_i;
          3'b111:  res = a & imm_i;
          default: wr = 1'b0;
        endcase
      end
      7'b0110011: begin
        wr = 1'b1;
        if (ins[31:25] == 7'h20 && f3 == 3'b000) begin
          res = a - b;
        end else if (ins[31:25] != 7'h00) begin
          wr = 1'b0;
        end else begin
          case (f3)
            3'b000:  res = a + b;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: wr = 1'b0;
          endcase
        end
      end
      7'b1100011: begin
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
          exp_pc <= exp_pc + imm_b;
        end
      end
      7'b0100011: begin
        if (f3 == 3'b010) begin
          exp_adr    <= (a + imm_s) & ~32'd3;
          exp_dat    <= b;
          st_pending <= 1'b1;
          st_ref     <= st_ref + 1;
        end
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) begin
      ref_regs[rd] = res;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_in) begin
      exp_pc     <= BOOT_ADR;
      st_pending <= 1'b0;
      fetch_cnt  <= 0;
      loop_hits  <= 0;
      st_ref     <= 0;
      st_seen    <= 0;
    end else begin
      if (dmem_stb_o && dmem_ack_i) begin
        st_pending <= 1'b0;
        st_seen    <= st_seen + 1;
      end
      if (imem_stb_o && imem_ack_i) begin
        fetch_cnt <= fetch_cnt + 1;
        // second hit means the end loop ran once and came back
        if (exp_pc == LOOP_ADR) begin
          loop_hits <= loop_hits + 1;
        end
        execute_ref(imem_dat_i);
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_rst_idle: assert property (@(posedge clk_i) !rst_in |=> !imem_stb_o && !dmem_stb_o)
    else begin
      err_cnt++;
      $display("Fail at %0t: strobe high during or right after reset", $time);
    end

  a_boot: assert property (@(posedge clk_i) disable iff (!rst_in)
    imem_stb_o && fetch_cnt == 0 |-> imem_adr_o == BOOT_ADR)
    else begin
      err_cnt++;
      $display("Fail at %0t: first fetch at %h", $time, $sampled(imem_adr_o));
    end

  a_fetch_pc: assert property (@(posedge clk_i) disable iff (!rst_in)
    imem_stb_o |-> imem_adr_o == exp_pc)
    else begin
      err_cnt++;
      $display("Fail at %0t: fetch address %h, expected %h", $time,
               $sampled(imem_adr_o), $sampled(exp_pc));
    end

  a_fetch_hold: assert property (@(posedge clk_i) disable iff (!rst_in)
    imem_stb_o && !imem_ack_i |=> imem_stb_o && $stable(imem_adr_o))
    else begin
      err_cnt++;
      $display("Fail at %0t: fetch request changed before ack", $time);
    end

  a_store: assert property (@(posedge clk_i) disable iff (!rst_in)
    dmem_stb_o |-> st_pending && dmem_we_o && dmem_adr_o == exp_adr && dmem_dat_o == exp_dat)
    else begin
      err_cnt++;
      $display("Fail at %0t: store %h <= %h, expected %h <= %h", $time,
               $sampled(dmem_adr_o), $sampled(dmem_dat_o),
               $sampled(exp_adr), $sampled(exp_dat));
    end

  a_store_hold: assert property (@(posedge clk_i) disable iff (!rst_in)
    dmem_stb_o && !dmem_ack_i |=>
      dmem_stb_o && $stable(dmem_adr_o) && $stable(dmem_dat_o))
    else begin
      err_cnt++;
      $display("Fail at %0t: store request changed before ack", $time);
    end

  a_excl: assert property (@(posedge clk_i) disable iff (!rst_in)
    !(imem_stb_o && dmem_stb_o))
    else begin
      err_cnt++;
      $display("Fail at %0t: both bus strobes high", $time);
    end

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    seed       = 32'h2ab4c1c3;
    err_cnt    = 0;
    to_cnt     = 0;
    cycles     = 0;
    rst_in     = 1'b0;
    imem_ack_i = 1'b0;
    imem_dat_i = NOP;
    dmem_ack_i = 1'b0;
    load_program();
    repeat (4) @(posedge clk_i);
    rst_in <= 1'b1;
    while (loop_hits < 2 && cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    if (loop_hits < 2) begin
      to_cnt++;
      $display("timeout: end loop not reached within %0d cycles", MAX_CYCLES);
    end
    // every predicted store reached the bus, and nothing is left open
    a_all_stores: assert (st_seen == st_ref && !st_pending)
      else begin
        err_cnt++;
        $display("Fail at %0t: %0d stores seen, %0d expected", $time, st_seen, st_ref);
      end
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $display("errors: %0d check failures, %0d timeouts", err_cnt, to_cnt);
    $finish;
  end

endmodule

// ==== flist.f ====
source/chunk_core_pkg.sv
source/chunk_pc.sv
source/chunk_cntrl.sv
source/chunk_decode.sv
source/chunk_regfile.sv
source/chunk_alu.sv
source/chunk_lsu.sv
source/chunk_core.sv
tb/chunk_core_tb.sv
